// File: Makefile
# Verilator flow for the RVFI retirement trace monitor
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= rvfi_mon_tb
LINT_TOP  ?= rvfi_mon_top
FILELIST  ?= rvfi_mon.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  -Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/rvfi_mon_tb.sv
module rvfi_mon_tb;
  import rvfi_mon_pkg::*;

  localparam int NUM_ROWS        = 15;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 12 + 200;

  localparam rvfi_trap_t NO_TRAP        = '0;
  localparam rvfi_intr_t NO_INTR        = '0;
  localparam xlen_t      ALL_ONES       = '1;
  localparam xlen_t      FIRST_ERR_FLAG = 32'h0000_0100;

  // One retired record and the STATUS bits it must raise
  typedef struct {
    string      name;
    dbg_cause_t dbg;
    dbg_cause_t dcsr_cause;
    logic       dbg_mode;
    rvfi_trap_t trap;
    rvfi_intr_t intr;
    xlen_t      wdata;
    xlen_t      wmask;
    logic       mem_access;
    int         xfers;
    err_vec_t   exp_status;
  } row_t;

  logic       clk_i;
  logic       rst_ni;
  logic       rvfi_valid;
  dbg_cause_t rvfi_dbg;
  dbg_cause_t rvfi_dcsr_cause;
  logic       rvfi_dbg_mode;
  rvfi_trap_t rvfi_trap;
  rvfi_intr_t rvfi_intr;
  xlen_t      rvfi_mcause_wdata;
  xlen_t      rvfi_mcause_wmask;
  logic       rvfi_mem_access;
  logic       bus_valid;
  logic       bus_ready;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  xlen_t      pwdata;
  xlen_t      prdata;
  logic       pready;
  logic       pslverr;
  logic       irq_o;

  row_t   rows[NUM_ROWS];
  row_t   first_err_rows[2];
  int     check_errors;
  int     test_start_errors;
  int     tests_passed;
  int     tests_failed;
  int     exp_err_cnt;
  int     exp_retire_cnt;
  integer seed;

  rvfi_mon_top #(
    .CLIC          (1'b0),
    .CLIC_ID_WIDTH (5)
  ) rvfi_mon_top_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rvfi_valid        (rvfi_valid),
    .rvfi_dbg          (rvfi_dbg),
    .rvfi_dcsr_cause   (rvfi_dcsr_cause),
    .rvfi_dbg_mode     (rvfi_dbg_mode),
    .rvfi_trap         (rvfi_trap),
    .rvfi_intr         (rvfi_intr),
    .rvfi_mcause_wdata (rvfi_mcause_wdata),
    .rvfi_mcause_wmask (rvfi_mcause_wmask),
    .rvfi_mem_access   (rvfi_mem_access),
    .bus_valid         (bus_valid),
    .bus_ready         (bus_ready),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .prdata            (prdata),
    .pready            (pready),
    .pslverr           (pslverr),
    .irq_o             (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic rvfi_trap_t exc_trap(input logic [5:0] cause);
    rvfi_trap_t t;
    t                 = '0;
    t.exception       = 1'b1;
    t.exception_cause = cause;
    return t;
  endfunction

  function automatic rvfi_trap_t dbg_trap(input dbg_cause_t cause);
    rvfi_trap_t t;
    t             = '0;
    t.debug       = 1'b1;
    t.debug_cause = cause;
    return t;
  endfunction

  function automatic rvfi_intr_t irq_intr(input exccode_t cause, input logic exc);
    rvfi_intr_t t;
    t           = '0;
    t.interrupt = 1'b1;
    t.exception = exc;
    t.cause     = cause;
    return t;
  endfunction

  // Columns: name, dbg, dcsr cause, dbg_mode, trap, intr, mcause wdata, wmask,
  // mem access, bus handshakes before the record, expected STATUS
  function automatic void load_table();
    rows[0]  = '{"normal instruction", 3'd0, 3'd0, 1'b0, NO_TRAP, NO_INTR,
                 32'h0, 32'h0, 1'b0, 0, 7'h00};
    rows[1]  = '{"exception with clean mcause", 3'd0, 3'd0, 1'b0, exc_trap(6'd2), NO_INTR,
                 32'h0000_0002, ALL_ONES, 1'b0, 0, 7'h00};
    rows[2]  = '{"clint interrupt cause 7", 3'd0, 3'd0, 1'b0, NO_TRAP, irq_intr(11'd7, 1'b0),
                 32'h0, 32'h0, 1'b0, 0, 7'h00};
    rows[3]  = '{"debug entry haltreq", 3'd3, 3'd3, 1'b0, dbg_trap(3'd3), NO_INTR,
                 32'h0, 32'h0, 1'b0, 0, 7'h00};
    rows[4]  = '{"wrong dcsr cause", 3'd1, 3'd2, 1'b0, dbg_trap(3'd1), NO_INTR,
                 32'h0, 32'h0, 1'b0, 0, 7'h01};
    // Mask hides bit 1, so the written code reads as 0
    rows[5]  = '{"masked mcause mismatch", 3'd0, 3'd0, 1'b0, exc_trap(6'd2), NO_INTR,
                 32'h0000_0002, 32'hFFFF_FFFC, 1'b0, 0, 7'h02};
    rows[6]  = '{"mcause interrupt bit set", 3'd0, 3'd0, 1'b0, exc_trap(6'd2), NO_INTR,
                 32'h8000_0002, ALL_ONES, 1'b0, 0, 7'h04};
    rows[7]  = '{"clint interrupt cause 12", 3'd0, 3'd0, 1'b0, NO_TRAP, irq_intr(11'd12, 1'b0),
                 32'h0, 32'h0, 1'b0, 0, 7'h08};
    rows[8]  = '{"exception cause 0", 3'd0, 3'd0, 1'b0, exc_trap(6'd0), NO_INTR,
                 32'h0, ALL_ONES, 1'b0, 0, 7'h10};
    rows[9]  = '{"sync and async handler", 3'd0, 3'd0, 1'b0, NO_TRAP, irq_intr(11'd7, 1'b1),
                 32'h0, 32'h0, 1'b0, 0, 7'h20};
    rows[10] = '{"instruction in debug mode", 3'd0, 3'd0, 1'b1, NO_TRAP, NO_INTR,
                 32'h0, 32'h0, 1'b0, 0, 7'h00};
    // Previous record was in debug mode
    rows[11] = '{"dcsr mismatch after debug", 3'd1, 3'd2, 1'b0, dbg_trap(3'd1), NO_INTR,
                 32'h0, 32'h0, 1'b0, 0, 7'h00};
    // Would break rules 1 and 2 outside debug mode
    rows[12] = '{"exception in debug mode", 3'd0, 3'd0, 1'b1, exc_trap(6'd2), NO_INTR,
                 32'h8000_0000, 32'h0, 1'b0, 0, 7'h00};
    rows[13] = '{"access without transfer", 3'd0, 3'd0, 1'b0, NO_TRAP, NO_INTR,
                 32'h0, 32'h0, 1'b1, 0, 7'h40};
    // One handshake pays back the earlier over-report, one covers this access
    rows[14] = '{"access after handshakes", 3'd0, 3'd0, 1'b0, NO_TRAP, NO_INTR,
                 32'h0, 32'h0, 1'b1, 2, 7'h00};

    first_err_rows[0] = '{"irq 12 with exception bit", 3'd0, 3'd0, 1'b0, NO_TRAP,
                          irq_intr(11'd12, 1'b1), 32'h0, 32'h0, 1'b0, 0, 7'h28};
    first_err_rows[1] = '{"second dcsr mismatch", 3'd1, 3'd2, 1'b0, dbg_trap(3'd1), NO_INTR,
                          32'h0, 32'h0, 1'b0, 0, 7'h01};
  endfunction

  task automatic check_value(input string sig, input xlen_t got, input xlen_t exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", sig, got, exp);
      check_errors++;
    end
  endtask

  task automatic start_test();
    test_start_errors = check_errors;
  endtask

  task automatic finish_test(input string name);
    if (check_errors == test_start_errors) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d wrong values", name, check_errors - test_start_errors);
    end
  endtask

  task automatic init_inputs();
    rst_ni            = 1'b0;
    rvfi_valid        = 1'b0;
    rvfi_dbg          = '0;
    rvfi_dcsr_cause   = '0;
    rvfi_dbg_mode     = 1'b0;
    rvfi_trap         = '0;
    rvfi_intr         = '0;
    rvfi_mcause_wdata = '0;
    rvfi_mcause_wmask = '0;
    rvfi_mem_access   = 1'b0;
    bus_valid         = 1'b0;
    bus_ready         = 1'b0;
    psel              = 1'b0;
    penable           = 1'b0;
    pwrite            = 1'b0;
    paddr             = '0;
    pwdata            = '0;
  endtask

  // All driving tasks start and end just after a falling edge
  task automatic drive_record(input row_t r);
    rvfi_valid        = 1'b1;
    rvfi_dbg          = r.dbg;
    rvfi_dcsr_cause   = r.dcsr_cause;
    rvfi_dbg_mode     = r.dbg_mode;
    rvfi_trap         = r.trap;
    rvfi_intr         = r.intr;
    rvfi_mcause_wdata = r.wdata;
    rvfi_mcause_wmask = r.wmask;
    rvfi_mem_access   = r.mem_access;
    @(negedge clk_i);
    rvfi_valid        = 1'b0;
  endtask

  task automatic drive_bus_xfer();
    bus_valid = 1'b1;
    bus_ready = 1'b1;
    @(negedge clk_i);
    bus_valid = 1'b0;
    bus_ready = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, input logic exp_err, output xlen_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk_i);
    penable = 1'b1;
    check_value("pready", xlen_t'(pready), 32'h1);
    check_value("pslverr", xlen_t'(pslverr), xlen_t'(exp_err));
    data = prdata;
    @(negedge clk_i);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input xlen_t data, input logic exp_err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk_i);
    penable = 1'b1;
    check_value("pready", xlen_t'(pready), 32'h1);
    check_value("pslverr", xlen_t'(pslverr), xlen_t'(exp_err));
    @(negedge clk_i);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_reset_values();
    xlen_t data;
    start_test();
    check_value("prdata", prdata, '0);
    check_value("pslverr", xlen_t'(pslverr), '0);
    check_value("irq_o", xlen_t'(irq_o), '0);
    apb_read(REG_STATUS, 1'b0, data);
    check_value("STATUS", data, '0);
    apb_read(REG_ERR_CNT, 1'b0, data);
    check_value("ERR_CNT", data, '0);
    apb_read(REG_RETIRE_CNT, 1'b0, data);
    check_value("RETIRE_CNT", data, '0);
    apb_read(REG_FIRST_ERR, 1'b0, data);
    check_value("FIRST_ERR", data, '0);
    finish_test("reset values");
  endtask

  task automatic run_row(input row_t r);
    xlen_t data;
    start_test();
    for (int k = 0; k < r.xfers; k++) begin
      drive_bus_xfer();
    end
    drive_record(r);
    // Registers hold the result once the three stage pipeline has drained
    repeat (4) @(negedge clk_i);
    exp_retire_cnt++;
    if (r.exp_status != '0) begin
      exp_err_cnt++;
    end
    check_value("irq_o", xlen_t'(irq_o), xlen_t'(r.exp_status != '0));
    apb_read(REG_STATUS, 1'b0, data);
    check_value("STATUS", data, xlen_t'(r.exp_status));
    apb_read(REG_ERR_CNT, 1'b0, data);
    check_value("ERR_CNT", data, xlen_t'(exp_err_cnt));
    apb_read(REG_RETIRE_CNT, 1'b0, data);
    check_value("RETIRE_CNT", data, xlen_t'(exp_retire_cnt));
    apb_write(REG_STATUS, ALL_ONES, 1'b0);
    check_value("irq_o", xlen_t'(irq_o), '0);
    finish_test(r.name);
  endtask

  task automatic check_first_err();
    xlen_t    data;
    err_vec_t exp_status;
    xlen_t    exp_first;
    start_test();
    drive_record(first_err_rows[0]);
    drive_record(first_err_rows[1]);
    repeat (4) @(negedge clk_i);
    exp_retire_cnt += 2;
    exp_err_cnt    += 2;
    exp_status = first_err_rows[0].exp_status | first_err_rows[1].exp_status;
    // Lowest rule of the first violating record
    exp_first  = FIRST_ERR_FLAG | xlen_t'(IRQ_CAUSE);
    check_value("irq_o", xlen_t'(irq_o), 32'h1);
    apb_read(REG_STATUS, 1'b0, data);
    check_value("STATUS", data, xlen_t'(exp_status));
    apb_read(REG_FIRST_ERR, 1'b0, data);
    check_value("FIRST_ERR", data, exp_first);
    apb_write(REG_STATUS, 32'h0000_0008, 1'b0);
    exp_status = exp_status & ~err_vec_t'(7'h08);
    apb_read(REG_STATUS, 1'b0, data);
    check_value("STATUS", data, xlen_t'(exp_status));
    apb_read(REG_FIRST_ERR, 1'b0, data);
    check_value("FIRST_ERR", data, exp_first);
    apb_write(REG_STATUS, xlen_t'(exp_status), 1'b0);
    check_value("irq_o", xlen_t'(irq_o), '0);
    apb_read(REG_FIRST_ERR, 1'b0, data);
    check_value("FIRST_ERR valid bit", data & FIRST_ERR_FLAG, '0);
    finish_test("first error and write-one clear");
  endtask

  task automatic check_err_cnt_clear();
    xlen_t data;
    xlen_t wval;
    start_test();
    apb_read(REG_ERR_CNT, 1'b0, data);
    check_value("ERR_CNT", data, xlen_t'(exp_err_cnt));
    wval = $random(seed);
    apb_write(REG_ERR_CNT, wval, 1'b0);
    exp_err_cnt = 0;
    apb_read(REG_ERR_CNT, 1'b0, data);
    check_value("ERR_CNT", data, '0);
    apb_read(REG_RETIRE_CNT, 1'b0, data);
    check_value("RETIRE_CNT", data, xlen_t'(exp_retire_cnt));
    finish_test("error counter clear");
  endtask

  task automatic check_read_only_writes();
    xlen_t data;
    start_test();
    apb_write(REG_RETIRE_CNT, ALL_ONES, 1'b0);
    apb_write(REG_FIRST_ERR, ALL_ONES, 1'b0);
    apb_read(REG_RETIRE_CNT, 1'b0, data);
    check_value("RETIRE_CNT", data, xlen_t'(exp_retire_cnt));
    apb_read(REG_FIRST_ERR, 1'b0, data);
    check_value("FIRST_ERR valid bit", data & FIRST_ERR_FLAG, '0);
    finish_test("read-only registers");
  endtask

  task automatic check_bad_offset();
    xlen_t data;
    start_test();
    apb_read(4'h2, 1'b1, data);
    apb_write(4'h2, ALL_ONES, 1'b1);
    apb_read(4'h5, 1'b1, data);
    // A good access after the errors answers without pslverr
    apb_read(REG_STATUS, 1'b0, data);
    check_value("STATUS", data, '0);
    check_value("irq_o", xlen_t'(irq_o), '0);
    finish_test("bad offset error");
  endtask

  initial begin
    init_inputs();
    seed           = 34;
    check_errors   = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    exp_err_cnt    = 0;
    exp_retire_cnt = 0;
    load_table();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_reset_values();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    check_first_err();
    check_err_cnt_clear();
    check_read_only_writes();
    check_bad_offset();
    $display("Tests: %0d passed, %0d failed, %0d wrong values",
             tests_passed, tests_failed, check_errors);
    if (tests_failed == 0 && check_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: rvfi_mon.f
verilog/rvfi_mon_pkg.sv
verilog/rvfi_capture.sv
verilog/rvfi_bus_audit.sv
verilog/rvfi_cause_check.sv
verilog/rvfi_err_regs.sv
verilog/rvfi_mon_top.sv
dv/rvfi_mon_tb.sv

// File: verilog/rvfi_bus_audit.sv
module rvfi_bus_audit (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic bus_valid,
  input  logic bus_ready,
  input  logic rvfi_valid,
  input  logic rvfi_mem_access,
  output logic bus_err
);
  import rvfi_mon_pkg::*;

  xlen_t bus_cnt_q;
  xlen_t bus_cnt_d;
  xlen_t mem_cnt_q;
  xlen_t mem_cnt_d;
  logic  xfer;
  logic  report;
  logic  over_report;

  // Data bus transfer happens on a valid/ready handshake
  assign xfer = bus_valid && bus_ready;

  // Retirement that claims a read or write
  assign report = rvfi_valid && rvfi_mem_access;

  assign bus_cnt_d = bus_cnt_q + xlen_t'(xfer);
  assign mem_cnt_d = mem_cnt_q + xlen_t'(report);

  // A transfer in the same cycle still covers the access
  // The reported count keeps running, so later over-reports stay visible
  assign over_report = report && (mem_cnt_d > bus_cnt_d);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt_q <= '0;
      mem_cnt_q <= '0;
    end else begin
      bus_cnt_q <= bus_cnt_d;
      mem_cnt_q <= mem_cnt_d;
    end
  end

  // One cycle pulse, aligned with the captured record
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_err <= 1'b0;
    end else begin
      bus_err <= over_report;
    end
  end

  a_bus_cnt_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus_cnt_q >= $past(bus_cnt_q)
  ) else $error("bus transfer count went down");

endmodule

// File: verilog/rvfi_capture.sv
module rvfi_capture (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      rvfi_valid,
  input  rvfi_mon_pkg::dbg_cause_t  rvfi_dbg,
  input  rvfi_mon_pkg::dbg_cause_t  rvfi_dcsr_cause,
  input  logic                      rvfi_dbg_mode,
  input  rvfi_mon_pkg::rvfi_trap_t  rvfi_trap,
  input  rvfi_mon_pkg::rvfi_intr_t  rvfi_intr,
  input  rvfi_mon_pkg::xlen_t       rvfi_mcause_wdata,
  input  rvfi_mon_pkg::xlen_t       rvfi_mcause_wmask,
  input  logic                      rvfi_mem_access,
  output rvfi_mon_pkg::rvfi_trace_t trace,
  output logic                      was_dbg_mode
);
  import rvfi_mon_pkg::*;

  rvfi_trace_t rec_d;

  // Pack the loose RVFI ports into one record
  always_comb begin
    rec_d              = '0;
    rec_d.valid        = rvfi_valid;
    rec_d.dbg          = rvfi_dbg;
    rec_d.dcsr_cause   = rvfi_dcsr_cause;
    rec_d.dbg_mode     = rvfi_dbg_mode;
    rec_d.trap         = rvfi_trap;
    rec_d.intr         = rvfi_intr;
    rec_d.mcause_wdata = rvfi_mcause_wdata;
    rec_d.mcause_wmask = rvfi_mcause_wmask;
    rec_d.mem_access   = rvfi_mem_access;
  end

  // Payload only moves on a retirement and valid drops otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace <= '0;
    end else if (rvfi_valid) begin
      trace <= rec_d;
    end else begin
      trace.valid <= 1'b0;
    end
  end

  // Debug mode of the retired instruction before the one now in trace
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode <= 1'b0;
    end else if (rvfi_valid) begin
      was_dbg_mode <= trace.dbg_mode;
    end
  end

  // A debug trap must come with a debug entry cause on rvfi_dbg
  a_dbg_trap_has_dbg: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid && rvfi_trap.debug |-> (rvfi_dbg != '0)
  ) else $error("rvfi_dbg is zero on a debug trap");

endmodule

// File: verilog/rvfi_cause_check.sv
module rvfi_cause_check #(
  parameter bit CLIC          = 1'b0,
  parameter int CLIC_ID_WIDTH = 5
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rvfi_mon_pkg::rvfi_trace_t trace,
  input  logic                      was_dbg_mode,
  input  logic                      bus_err,
  output rvfi_mon_pkg::err_vec_t    err_vec,
  output logic                      err_valid
);
  import rvfi_mon_pkg::*;

  exccode_t mcause_code;
  logic     exc_checked;
  logic     irq_legal;
  logic     no_cause;
  err_vec_t rule_hit;
  err_vec_t err_vec_d;

  // Exception code part of the masked mcause write
  assign mcause_code = exccode_t'(trace.mcause_wdata & trace.mcause_wmask);

  // mcause is not written for exceptions taken in debug mode
  assign exc_checked = trace.trap.exception && !trace.dbg_mode;

  // Legal interrupt causes depend on the interrupt controller
  if (CLIC) begin : gen_clic
    localparam logic [31:0] MAX_CLIC_ID = 32'(2**CLIC_ID_WIDTH - 1);

    assign irq_legal = (32'(trace.intr.cause) <= MAX_CLIC_ID) ||
                       (trace.intr.cause inside {[11'd1024:11'd1027]});
  end else begin : gen_clint
    assign irq_legal = trace.intr.cause inside {11'd3, 11'd7, 11'd11,
                                                [11'd16:11'd31],
                                                [11'd1024:11'd1027]};
  end

  // CLIC allows interrupt id 0, CLINT does not
  assign no_cause =
      (trace.trap.exception && (trace.trap.exception_cause == '0)) ||
      (trace.trap.debug && (trace.trap.debug_cause == '0)) ||
      (!CLIC && trace.intr.interrupt && (trace.intr.cause == '0));

  always_comb begin
    rule_hit = '0;

    rule_hit[DBG_CAUSE] = (trace.dbg != '0) && !was_dbg_mode &&
                          (trace.dbg != trace.dcsr_cause);

    rule_hit[EXC_CAUSE] = exc_checked &&
                          (exccode_t'(trace.trap.exception_cause) != mcause_code);

    // Exceptions must write mcause.interrupt to zero
    rule_hit[EXC_MCAUSE_INT] = exc_checked &&
                               (!trace.mcause_wmask[31] || trace.mcause_wdata[31]);

    rule_hit[IRQ_CAUSE]     = trace.intr.interrupt && !irq_legal;
    rule_hit[NO_CAUSE]      = no_cause;
    rule_hit[HANDLER_AMBIG] = trace.intr.interrupt && trace.intr.exception;

    err_vec_d = trace.valid ? rule_hit : '0;
    // Bus audit result lines up with this record already
    err_vec_d[BUS_OVERREPORT] = err_vec_d[BUS_OVERREPORT] | bus_err;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_vec   <= '0;
      err_valid <= 1'b0;
    end else begin
      err_vec   <= err_vec_d;
      err_valid <= trace.valid;
    end
  end

  // Holds only if the bus audit flags nothing between records
  a_err_needs_record: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !err_valid |-> (err_vec == '0)
  ) else $error("err_vec set without a record");

  // Audit and capture must agree on which record reported the access
  a_bus_err_on_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus_err |-> (trace.valid && trace.mem_access)
  ) else $error("bus_err on a record without memory access");

endmodule

// File: verilog/rvfi_err_regs.sv
module rvfi_err_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  rvfi_mon_pkg::err_vec_t err_vec,
  input  logic                   err_valid,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  rvfi_mon_pkg::apb_addr_t paddr,
  input  rvfi_mon_pkg::xlen_t    pwdata,
  output rvfi_mon_pkg::xlen_t    prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   irq_o
);
  import rvfi_mon_pkg::*;

  apb_state_e state_q;
  apb_state_e state_d;
  logic       setup;
  logic       access;
  logic       addr_ok;
  logic       wr_status;
  logic       wr_err_cnt;
  logic       any_err;
  err_vec_t   status_q;
  err_vec_t   status_d;
  xlen_t      err_cnt_q;
  xlen_t      err_cnt_d;
  xlen_t      retire_cnt_q;
  logic       first_valid_q;
  rule_e      first_rule_q;
  rule_e      low_rule;
  xlen_t      first_err_rd;
  xlen_t      rd_data;

  // No wait states
  assign pready = 1'b1;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (psel) state_d = ACCESS;
      ACCESS:  if (penable || !psel) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign setup  = (state_q == IDLE) && psel;
  assign access = (state_q == ACCESS) && psel && penable;

  always_comb begin
    unique case (paddr)
      REG_STATUS, REG_ERR_CNT, REG_RETIRE_CNT, REG_FIRST_ERR: addr_ok = 1'b1;
      default: addr_ok = 1'b0;
    endcase
  end

  assign wr_status  = access && pwrite && (paddr == REG_STATUS);
  assign wr_err_cnt = access && pwrite && (paddr == REG_ERR_CNT);
  assign any_err    = err_valid && (err_vec != '0);

  // Clear first, then merge the new record
  always_comb begin
    status_d = status_q;
    if (wr_status) begin
      status_d = status_d & ~pwdata[NUM_RULES-1:0];
    end
    if (err_valid) begin
      status_d = status_d | err_vec;
    end
  end

  assign err_cnt_d = (wr_err_cnt ? '0 : err_cnt_q) + xlen_t'(any_err);

  // Lowest set rule index
  always_comb begin
    low_rule = DBG_CAUSE;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (err_vec[i]) low_rule = rule_e'(3'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q      <= '0;
      err_cnt_q     <= '0;
      retire_cnt_q  <= '0;
      first_valid_q <= 1'b0;
      first_rule_q  <= DBG_CAUSE;
    end else begin
      status_q     <= status_d;
      err_cnt_q    <= err_cnt_d;
      retire_cnt_q <= retire_cnt_q + xlen_t'(err_valid);
      if (status_d == '0) begin
        first_valid_q <= 1'b0;
      end else if (!first_valid_q && any_err) begin
        first_valid_q <= 1'b1;
        first_rule_q  <= low_rule;
      end
    end
  end

  always_comb begin
    first_err_rd                      = '0;
    first_err_rd[2:0]                 = first_rule_q;
    first_err_rd[FIRST_ERR_VALID_BIT] = first_valid_q;
  end

  always_comb begin
    unique case (paddr)
      REG_STATUS:     rd_data = xlen_t'(status_q);
      REG_ERR_CNT:    rd_data = err_cnt_q;
      REG_RETIRE_CNT: rd_data = retire_cnt_q;
      REG_FIRST_ERR:  rd_data = first_err_rd;
      default:        rd_data = '0;
    endcase
  end

  // Response is loaded in setup and held through the access phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else if (setup) begin
      prdata  <= pwrite ? '0 : rd_data;
      pslverr <= !addr_ok;
    end else if (access) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end
  end

  assign irq_o = (status_q != '0);

  a_penable_needs_psel: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    penable |-> psel
  ) else $error("penable high without psel");

endmodule

// File: verilog/rvfi_mon_pkg.sv
package rvfi_mon_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0] xlen_t;
  typedef logic [10:0] exccode_t;

  // Debug cause encoding: 1 ebreak, 2 trigger, 3 haltreq, 4 step
  typedef logic [2:0] dbg_cause_t;

  typedef struct packed {
    logic       exception;
    logic [5:0] exception_cause;
    logic       debug;
    logic [2:0] debug_cause;
  } rvfi_trap_t;

  typedef struct packed {
    logic     interrupt;
    logic     exception;
    exccode_t cause;
  } rvfi_intr_t;

  // One retired instruction as seen on RVFI
  typedef struct packed {
    logic       valid;
    dbg_cause_t dbg;
    dbg_cause_t dcsr_cause;   // dcsr[8:6]
    logic       dbg_mode;
    rvfi_trap_t trap;
    rvfi_intr_t intr;
    xlen_t      mcause_wdata;
    xlen_t      mcause_wmask;
    logic       mem_access;
  } rvfi_trace_t;

  // Rule indices, also the bit positions in STATUS
  typedef enum logic [2:0] {
    DBG_CAUSE      = 3'd0,
    EXC_CAUSE      = 3'd1,
    EXC_MCAUSE_INT = 3'd2,
    IRQ_CAUSE      = 3'd3,
    NO_CAUSE       = 3'd4,
    HANDLER_AMBIG  = 3'd5,
    BUS_OVERREPORT = 3'd6
  } rule_e;

  localparam int unsigned NUM_RULES = 7;

  typedef logic [NUM_RULES-1:0] err_vec_t;

  // APB register map
  typedef logic [3:0] apb_addr_t;

  localparam apb_addr_t REG_STATUS     = 4'h0;
  localparam apb_addr_t REG_ERR_CNT    = 4'h4;
  localparam apb_addr_t REG_RETIRE_CNT = 4'h8;
  localparam apb_addr_t REG_FIRST_ERR  = 4'hC;

  // FIRST_ERR holds the rule index in the low bits and a valid flag here
  localparam int unsigned FIRST_ERR_VALID_BIT = 8;

  typedef enum logic {
    IDLE,
    ACCESS
  } apb_state_e;

endpackage

// File: verilog/rvfi_mon_top.sv
module rvfi_mon_top #(
  parameter bit CLIC          = 1'b0,
  parameter int CLIC_ID_WIDTH = 5
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rvfi_valid,
  input  rvfi_mon_pkg::dbg_cause_t rvfi_dbg,
  input  rvfi_mon_pkg::dbg_cause_t rvfi_dcsr_cause,
  input  logic                     rvfi_dbg_mode,
  input  rvfi_mon_pkg::rvfi_trap_t rvfi_trap,
  input  rvfi_mon_pkg::rvfi_intr_t rvfi_intr,
  input  rvfi_mon_pkg::xlen_t      rvfi_mcause_wdata,
  input  rvfi_mon_pkg::xlen_t      rvfi_mcause_wmask,
  input  logic                     rvfi_mem_access,
  input  logic                     bus_valid,
  input  logic                     bus_ready,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  rvfi_mon_pkg::apb_addr_t  paddr,
  input  rvfi_mon_pkg::xlen_t      pwdata,
  output rvfi_mon_pkg::xlen_t      prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     irq_o
);
  import rvfi_mon_pkg::*;

  rvfi_trace_t trace;
  logic        was_dbg_mode;
  logic        bus_err;
  err_vec_t    err_vec;
  logic        err_valid;

  // Stage 1
  rvfi_capture u_capture (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rvfi_valid        (rvfi_valid),
    .rvfi_dbg          (rvfi_dbg),
    .rvfi_dcsr_cause   (rvfi_dcsr_cause),
    .rvfi_dbg_mode     (rvfi_dbg_mode),
    .rvfi_trap         (rvfi_trap),
    .rvfi_intr         (rvfi_intr),
    .rvfi_mcause_wdata (rvfi_mcause_wdata),
    .rvfi_mcause_wmask (rvfi_mcause_wmask),
    .rvfi_mem_access   (rvfi_mem_access),
    .trace             (trace),
    .was_dbg_mode      (was_dbg_mode)
  );

  // Side branch into stage 2
  rvfi_bus_audit u_bus_audit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bus_valid       (bus_valid),
    .bus_ready       (bus_ready),
    .rvfi_valid      (rvfi_valid),
    .rvfi_mem_access (rvfi_mem_access),
    .bus_err         (bus_err)
  );

  // Stage 2
  rvfi_cause_check #(
    .CLIC          (CLIC),
    .CLIC_ID_WIDTH (CLIC_ID_WIDTH)
  ) u_cause_check (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .trace        (trace),
    .was_dbg_mode (was_dbg_mode),
    .bus_err      (bus_err),
    .err_vec      (err_vec),
    .err_valid    (err_valid)
  );

  // Stage 3
  rvfi_err_regs u_err_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .err_vec   (err_vec),
    .err_valid (err_valid),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .irq_o     (irq_o)
  );

endmodule
